// ==== rtl/adder_consts.svh ====
// adder constants: operand width and depth of the prefix network
`ifndef ADDER_CONSTS_SVH
`define ADDER_CONSTS_SVH

//--------------------------------------------------
// datapath width
//--------------------------------------------------

// bits per operand, sum and carry vector
`define ADDER_WIDTH 32

//--------------------------------------------------
// prefix network
//--------------------------------------------------

// rows of combining cells, log2 of the width
`define PREFIX_LEVELS 5

`endif

// ==== rtl/adder_types_pkg.sv ====
// types seen at the adder boundary: operands, sum and carry vector
`default_nettype none

`include "adder_consts.svh"

package adder_types_pkg;

	//--------------------------------------------------
	// operand and result words
	//--------------------------------------------------

	// one operand or one sum
	typedef logic [`ADDER_WIDTH-1:0] word_t;

	// carry leaving each bit position
	// bit i is the carry out of bit i, so the top bit is the adder carry out
	typedef logic [`ADDER_WIDTH-1:0] carry_vec_t;

endpackage

`default_nettype wire

// ==== rtl/prefix_pkg.sv ====
// types of the generate/propagate vectors inside the prefix network
`default_nettype none

`include "adder_consts.svh"

package prefix_pkg;

	//--------------------------------------------------
	// generate/propagate vectors
	//--------------------------------------------------

	// one generate or one propagate value per bit position
	// after row k, position i covers the group from i down to i-2^(k+1)+1
	typedef logic [`ADDER_WIDTH-1:0] gp_vec_t;

endpackage

`default_nettype wire

// ==== rtl/ks_gp_init.sv ====
// bitwise generate and propagate, with carry-in merged into bit 0
`default_nettype none

`include "adder_consts.svh"

module ks_gp_init
(
	input  adder_types_pkg::word_t a,
	input  adder_types_pkg::word_t b,
	input  logic                   carry_in,
	output prefix_pkg::gp_vec_t    gen,
	output prefix_pkg::gp_vec_t    prop
);
	import prefix_pkg::*;

	gp_vec_t gen_raw;
	gp_vec_t prop_raw;

	// plain two-operand terms, propagate as or
	assign gen_raw  = a & b;
	assign prop_raw = a | b;

	// bit 0 treats carry_in as a third operand
	// majority of a, b, cin written as ab + (a+b)cin
	assign gen[0]  = gen_raw[0] | (prop_raw[0] & carry_in);
	assign prop[0] = prop_raw[0] | carry_in;

	// upper bits unchanged
	assign gen[`ADDER_WIDTH-1:1]  = gen_raw[`ADDER_WIDTH-1:1];
	assign prop[`ADDER_WIDTH-1:1] = prop_raw[`ADDER_WIDTH-1:1];

	// bit 0 generate must be high when two or more of its inputs are set
	always_comb
	begin
		assert final (gen[0] == ($countones({a[0], b[0], carry_in}) >= 2))
		else
			$error("ks_gp_init: bit 0 generate is not the majority of a, b, carry_in");
	end

endmodule

`default_nettype wire

// ==== rtl/ks_prefix_level.sv ====
// one kogge-stone row of generate/propagate combining cells at a fixed span
`default_nettype none

`include "adder_consts.svh"

module ks_prefix_level
#(
	parameter int unsigned SPAN = 1
)
(
	input  prefix_pkg::gp_vec_t gen_in,
	input  prefix_pkg::gp_vec_t prop_in,
	output prefix_pkg::gp_vec_t gen_out,
	output prefix_pkg::gp_vec_t prop_out
);
	genvar i;

	//--------------------------------------------------
	// per-position cells
	//--------------------------------------------------
	for (i = 0; i < `ADDER_WIDTH; i++)
	begin : g_bit
		if (i >= SPAN)
		begin : g_cell
			// high group generates, or propagates a low generate
			assign gen_out[i]  = gen_in[i] | (prop_in[i] & gen_in[i-SPAN]);
			assign prop_out[i] = prop_in[i] & prop_in[i-SPAN];
		end
		else
		begin : g_pass
			// no partner below, group already reaches bit 0
			assign gen_out[i]  = gen_in[i];
			assign prop_out[i] = prop_in[i];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/ks_prefix_tree.sv ====
// kogge-stone prefix network, stacks the rows and taps the carry vector
`default_nettype none

`include "adder_consts.svh"

module ks_prefix_tree
(
	input  prefix_pkg::gp_vec_t         gen,
	input  prefix_pkg::gp_vec_t         prop,
	output adder_types_pkg::carry_vec_t carries
);
	import prefix_pkg::*;

	// row 0 is the bitwise stage, row k+1 the output of level k
	gp_vec_t gen_row  [`PREFIX_LEVELS+1];
	gp_vec_t prop_row [`PREFIX_LEVELS];

	assign gen_row[0]  = gen;
	assign prop_row[0] = prop;

	genvar lvl;

	//--------------------------------------------------
	// rows with spans 1, 2, 4, 8, 16
	//--------------------------------------------------
	for (lvl = 0; lvl < `PREFIX_LEVELS; lvl++)
	begin : g_row
		if (lvl < `PREFIX_LEVELS - 1)
		begin : g_mid
			ks_prefix_level
			#(
				.SPAN (1 << lvl)
			)
			u_level
			(
				.gen_in   (gen_row[lvl]),
				.prop_in  (prop_row[lvl]),
				.gen_out  (gen_row[lvl+1]),
				.prop_out (prop_row[lvl+1])
			);
		end
		else
		begin : g_last
			// last row only needs its generate
			ks_prefix_level
			#(
				.SPAN (1 << lvl)
			)
			u_level
			(
				.gen_in   (gen_row[lvl]),
				.prop_in  (prop_row[lvl]),
				.gen_out  (gen_row[lvl+1]),
				.prop_out ()
			);
		end
	end

	//--------------------------------------------------
	// carry taps
	//--------------------------------------------------

	// group generate from bit 0 up to i is the carry out of bit i
	assign carries = gen_row[`PREFIX_LEVELS];

	// bit 0 has no partner in any row, so its carry is its own generate
	always_comb
	begin
		assert final (carries[0] == gen[0])
		else
			$error("ks_prefix_tree: carry 0 differs from bit 0 generate");
	end

endmodule

`default_nettype wire

// ==== rtl/ks_sum.sv ====
// sum stage, three-way xor of operand bits and the carry from below
`default_nettype none

`include "adder_consts.svh"

module ks_sum
(
	input  adder_types_pkg::word_t      a,
	input  adder_types_pkg::word_t      b,
	input  adder_types_pkg::carry_vec_t carries,
	input  logic                        carry_in,
	output adder_types_pkg::word_t      sum
);
	import adder_types_pkg::*;

	// carry entering each bit position
	word_t carry_into;

	// carry_in feeds bit 0, every other bit takes the carry out of its neighbour
	// top carry leaves the adder and is not summed
	assign carry_into = {carries[`ADDER_WIDTH-2:0], carry_in};

	assign sum = a ^ b ^ carry_into;

endmodule

`default_nettype wire

// ==== rtl/ks_adder_top.sv ====
// 32-bit kogge-stone adder with carry-in, result registered on the input strobe
`default_nettype none

module ks_adder_top
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        in_valid,
	input  adder_types_pkg::word_t      a,
	input  adder_types_pkg::word_t      b,
	input  logic                        carry_in,
	output logic                        out_valid,
	output adder_types_pkg::word_t      sum,
	output adder_types_pkg::carry_vec_t carry_out
);
	import adder_types_pkg::*;
	import prefix_pkg::*;

	gp_vec_t    gen;
	gp_vec_t    prop;
	carry_vec_t carries;
	word_t      sum_comb;

	//--------------------------------------------------
	// combinational datapath
	//--------------------------------------------------
	ks_gp_init u_gp_init
	(
		.a        (a),
		.b        (b),
		.carry_in (carry_in),
		.gen      (gen),
		.prop     (prop)
	);

	ks_prefix_tree u_prefix_tree
	(
		.gen     (gen),
		.prop    (prop),
		.carries (carries)
	);

	ks_sum u_sum
	(
		.a        (a),
		.b        (b),
		.carries  (carries),
		.carry_in (carry_in),
		.sum      (sum_comb)
	);

	//--------------------------------------------------
	// output register
	//--------------------------------------------------

	// capture on the strobe, hold otherwise
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			sum       <= '0;
			carry_out <= '0;
		end
		else
		begin
			out_valid <= in_valid;
			if (in_valid)
			begin
				sum       <= sum_comb;
				carry_out <= carries;
			end
		end
	end

	//--------------------------------------------------
	// checks
	//--------------------------------------------------

	// a result only appears after a strobe taken outside reset
	assert property (@(posedge clk) disable iff (reset)
		out_valid |-> ($past(in_valid) && !$past(reset)))
	else
		$error("ks_adder_top: out_valid without a strobe the cycle before");

	// nothing left over from before reset
	assert property (@(posedge clk) reset |=> !out_valid)
	else
		$error("ks_adder_top: out_valid high in the cycle after reset");

	// whole prefix datapath against a plain addition of the captured inputs
	assert property (@(posedge clk) disable iff (reset)
		out_valid |-> (sum == $past(a + b + carry_in)))
	else
		$error("ks_adder_top: registered sum differs from a + b + carry_in");

endmodule

`default_nettype wire

// ==== tests/ks_adder_tb.sv ====
// self-checking testbench for the registered kogge-stone adder, table and random operands
`default_nettype none

`include "adder_consts.svh"

module ks_adder_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import adder_types_pkg::*;

	localparam int TABLE_ROWS  = 8;
	localparam int RANDOM_RUNS = 24;
	localparam int BURST_LEN   = 16;
	localparam int WAIT_LIMIT  = 10;

	logic       clk;
	logic       reset;
	logic       in_valid;
	word_t      a;
	word_t      b;
	logic       carry_in;
	logic       out_valid;
	word_t      sum;
	carry_vec_t carry_out;

	int          checks;
	int          errors;
	bit          timed_out;
	logic [31:0] lfsr_state;

	// operand table with hand-derived sums
	word_t table_a   [TABLE_ROWS];
	word_t table_b   [TABLE_ROWS];
	logic  table_cin [TABLE_ROWS];
	word_t table_sum [TABLE_ROWS];
	string table_name [TABLE_ROWS];

	ks_adder_top dut0
	(
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.carry_in  (carry_in),
		.out_valid (out_valid),
		.sum       (sum),
		.carry_out (carry_out)
	);

	// 4 ns period
	always #2 clk = ~clk;

	//--------------------------------------------------
	// reference model
	//--------------------------------------------------

	function automatic word_t ref_sum(input word_t op_a, input word_t op_b, input logic cin);
		logic [`ADDER_WIDTH:0] full;
		full = {1'b0, op_a} + {1'b0, op_b} + cin;
		return full[`ADDER_WIDTH-1:0];
	endfunction

	// ripple through the bits, carry out is the majority of the three inputs
	function automatic carry_vec_t ref_carries(input word_t op_a, input word_t op_b,
			input logic cin);
		carry_vec_t result;
		logic       c;
		c = cin;
		for (int i = 0; i < `ADDER_WIDTH; i++)
		begin
			result[i] = (op_a[i] & op_b[i]) | (op_a[i] & c) | (op_b[i] & c);
			c = result[i];
		end
		return result;
	endfunction

	//--------------------------------------------------
	// random source
	//--------------------------------------------------

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one step per bit taken
	task automatic random_word(output logic [31:0] value, input int nbits);
		value = '0;
		for (int i = 0; i < nbits; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	//--------------------------------------------------
	// checking and waiting
	//--------------------------------------------------

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// waiting starts at the falling edge after the strobe
	task automatic wait_for_result(input string name, output int waited);
		waited = 0;
		while (out_valid !== 1'b1 && waited < WAIT_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (out_valid !== 1'b1)
		begin
			errors++;
			timed_out = 1'b1;
			$display("%s: out_valid did not rise within %0d cycles", name, WAIT_LIMIT);
		end
	endtask

	//--------------------------------------------------
	// stimulus
	//--------------------------------------------------

	task automatic add_row(input int idx, input word_t op_a, input word_t op_b,
			input logic cin, input word_t exp_sum, input string name);
		table_a[idx]    = op_a;
		table_b[idx]    = op_b;
		table_cin[idx]  = cin;
		table_sum[idx]  = exp_sum;
		table_name[idx] = name;
	endtask

	task automatic load_table();
		add_row(0, 32'h00000000, 32'h00000000, 1'b0, 32'h00000000, "zero plus zero");
		add_row(1, 32'hffffffff, 32'h00000001, 1'b0, 32'h00000000, "ones plus one");
		add_row(2, 32'haaaaaaaa, 32'h55555555, 1'b0, 32'hffffffff, "alternating");
		add_row(3, 32'haaaaaaaa, 32'h55555555, 1'b1, 32'h00000000, "alternating cin");
		add_row(4, 32'hffffffff, 32'h00000000, 1'b1, 32'h00000000, "ones with cin");
		add_row(5, 32'h55555555, 32'h55555555, 1'b0, 32'haaaaaaaa, "fives doubled");
		add_row(6, 32'hffffffff, 32'hffffffff, 1'b1, 32'hffffffff, "all ones cin");
		add_row(7, 32'h12345678, 32'h9abcdef0, 1'b0, 32'hacf13568, "mixed");
	endtask

	// single strobe, then one idle cycle with changed inputs
	task automatic apply_one(input string name, input word_t op_a, input word_t op_b,
			input logic cin, input word_t exp_sum);
		int         waited;
		carry_vec_t exp_carries;
		exp_carries = ref_carries(op_a, op_b, cin);
		@(negedge clk);
		a        = op_a;
		b        = op_b;
		carry_in = cin;
		in_valid = 1'b1;
		@(negedge clk);
		in_valid = 1'b0;
		wait_for_result(name, waited);
		if (timed_out)
			return;
		check_value({name, " latency"}, 1, waited + 1);
		check_value({name, " sum"}, exp_sum, sum);
		check_value({name, " carries"}, exp_carries, carry_out);
		// new operands without a strobe must not reach the outputs
		a        = ~op_a;
		b        = op_b ^ 32'h5a5a5a5a;
		carry_in = ~cin;
		@(negedge clk);
		check_value({name, " idle out_valid"}, 0, out_valid);
		check_value({name, " held sum"}, exp_sum, sum);
		check_value({name, " held carries"}, exp_carries, carry_out);
	endtask

	// one strobe per cycle, results checked in order one cycle later
	task automatic run_burst(input int count);
		word_t       exp_sum_q [$];
		carry_vec_t  exp_carry_q [$];
		logic [31:0] op_a;
		logic [31:0] op_b;
		logic [31:0] bit_word;
		@(negedge clk);
		for (int i = 0; i <= count; i++)
		begin
			if (i > 0)
			begin
				check_value($sformatf("burst %0d out_valid", i - 1), 1, out_valid);
				check_value($sformatf("burst %0d sum", i - 1), exp_sum_q.pop_front(), sum);
				check_value($sformatf("burst %0d carries", i - 1), exp_carry_q.pop_front(),
						carry_out);
			end
			if (i < count)
			begin
				random_word(op_a, 32);
				random_word(op_b, 32);
				random_word(bit_word, 1);
				a        = op_a;
				b        = op_b;
				carry_in = bit_word[0];
				in_valid = 1'b1;
				exp_sum_q.push_back(ref_sum(op_a, op_b, bit_word[0]));
				exp_carry_q.push_back(ref_carries(op_a, op_b, bit_word[0]));
			end
			else
				in_valid = 1'b0;
			@(negedge clk);
		end
		check_value("burst end out_valid", 0, out_valid);
	endtask

	//--------------------------------------------------
	// main sequence
	//--------------------------------------------------
	initial
	begin
		logic [31:0] op_a;
		logic [31:0] op_b;
		logic [31:0] bit_word;
		clk        = 1'b0;
		reset      = 1'b1;
		in_valid   = 1'b0;
		a          = '0;
		b          = '0;
		carry_in   = 1'b0;
		checks     = 0;
		errors     = 0;
		timed_out  = 1'b0;
		lfsr_state = 32'h3976;
		load_table();

		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// cleared outputs before any strobe
		@(negedge clk);
		check_value("reset out_valid", 0, out_valid);
		check_value("reset sum", 0, sum);
		check_value("reset carries", 0, carry_out);

		for (int r = 0; r < TABLE_ROWS && !timed_out; r++)
			apply_one(table_name[r], table_a[r], table_b[r], table_cin[r], table_sum[r]);

		for (int r = 0; r < RANDOM_RUNS && !timed_out; r++)
		begin
			random_word(op_a, 32);
			random_word(op_b, 32);
			random_word(bit_word, 1);
			apply_one($sformatf("random %0d", r), op_a, op_b, bit_word[0],
					ref_sum(op_a, op_b, bit_word[0]));
		end

		if (!timed_out)
			run_burst(BURST_LEN);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+rtl
rtl/adder_types_pkg.sv
rtl/prefix_pkg.sv
rtl/ks_gp_init.sv
rtl/ks_prefix_level.sv
rtl/ks_prefix_tree.sv
rtl/ks_sum.sv
rtl/ks_adder_top.sv
tests/ks_adder_tb.sv

// ==== Bender.yml ====
package:
  name: ks_adder

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/adder_types_pkg.sv
      - rtl/prefix_pkg.sv
      - rtl/ks_gp_init.sv
      - rtl/ks_prefix_level.sv
      - rtl/ks_prefix_tree.sv
      - rtl/ks_sum.sv
      - rtl/ks_adder_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/ks_adder_tb.sv
